//--- crt_ref_trigger.sv
`default_nettype none

module crt_ref_trigger (
  input  logic mem_clk,
  input  logic hreset_n,
  input  logic line_end,
  input  logic cr11_b6,
  output logic sync_line_end,
  output logic cr11_long
);

  logic line_end_q;
  logic line_end_rise;

  // Only the first cycle of a line end counts.
  assign line_end_rise = line_end & ~line_end_q;

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      line_end_q <= 1'b0;
    end else begin
      line_end_q <= line_end;
    end
  end

  // Start pulse shared by all banks.
  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      sync_line_end <= 1'b0;
    end else begin
      sync_line_end <= line_end_rise;
    end
  end

  // Burst length is sampled once per line and held until the next one,
  // so a CR11 write in mid line only affects the following line.
  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      cr11_long <= 1'b0;
    end else if (line_end_rise) begin
      cr11_long <= cr11_b6;            // Visible with sync_line_end.
    end
  end

endmodule

`default_nettype wire

//--- mem_ref_config.svh
`ifndef MEM_REF_CONFIG_SVH
`define MEM_REF_CONFIG_SVH

// Number of bank refresh sequencers.
`define MEM_BANKS 4

// Refresh cycles per burst, CR11 bit 6 clear.
`define REF_CNT_SHORT 3

// Refresh cycles per burst, CR11 bit 6 set.
`define REF_CNT_LONG 5

// Width of the per-bank refresh counter.
`define REF_CNT_W 3

// Cycles of svga_req before the arbiter acks the access.
`define REF_ACK_DELAY 2

`endif

//--- mem_ref_pkg.sv
`default_nettype none

`include "mem_ref_config.svh"

package mem_ref_pkg;

  // Refresh sequencer states, legacy encoding.
  typedef enum logic [2:0] {
    ref_idle    = 3'b000,
    ref_request = 3'b001,
    ref_access  = 3'b100,
    ref_count   = 3'b010,
    ref_check   = 3'b011,
    ref_done    = 3'b111
  } ref_state_e;

  localparam int unsigned bank_idx_w = (`MEM_BANKS > 1) ? $clog2(`MEM_BANKS) : 1;

  typedef logic [bank_idx_w-1:0] bank_idx_t;

  // Sequencer to arbiter.
  typedef struct packed {
    logic ref_req;
    logic svga_req;
  } bank_req_t;

  // Arbiter to sequencer.
  typedef struct packed {
    logic ref_gnt;
    logic svga_ack;
  } bank_ctl_t;

  // Observable refresh activity.
  typedef struct packed {
    logic      strobe;
    logic      done;
    bank_idx_t bank;
  } ref_event_t;

endpackage

`default_nettype wire

//--- mem_ref_top.sv
`default_nettype none

`include "mem_ref_config.svh"

module mem_ref_top (
  input  logic                    mem_clk,
  input  logic                    hreset_n,
  input  logic                    line_end,
  input  logic                    cr11_b6,
  output mem_ref_pkg::ref_event_t ref_event,
  output logic                    ref_strobe_n
);

  logic                                   sync_line_end;
  logic                                   cr11_long;
  mem_ref_pkg::bank_req_t [`MEM_BANKS-1:0] bank_req;
  mem_ref_pkg::bank_ctl_t [`MEM_BANKS-1:0] bank_ctl;
  logic                   [`MEM_BANKS-1:0] bank_done;

  crt_ref_trigger u_trigger (
    .mem_clk       (mem_clk),
    .hreset_n      (hreset_n),
    .line_end      (line_end),
    .cr11_b6       (cr11_b6),
    .sync_line_end (sync_line_end),
    .cr11_long     (cr11_long)
  );

  // One sequencer per bank, all started by the same line end.
  for (genvar b = 0; b < `MEM_BANKS; b++) begin : g_bank
    sm_ref u_sm_ref (
      .mem_clk        (mem_clk),
      .hreset_n       (hreset_n),
      .sync_line_end  (sync_line_end),
      .cr11_long      (cr11_long),
      .ctl            (bank_ctl[b]),
      .req            (bank_req[b]),
      .ref_cycle_done (bank_done[b])
    );
  end

  ref_arbiter u_arbiter (
    .mem_clk      (mem_clk),
    .hreset_n     (hreset_n),
    .req          (bank_req),
    .cycle_done   (bank_done),
    .ctl          (bank_ctl),
    .ref_event    (ref_event),
    .ref_strobe_n (ref_strobe_n)
  );

endmodule

`default_nettype wire

//--- ref_arbiter.sv
`default_nettype none

`include "mem_ref_config.svh"

module ref_arbiter (
  input  logic                                   mem_clk,
  input  logic                                   hreset_n,
  input  mem_ref_pkg::bank_req_t [`MEM_BANKS-1:0] req,
  input  logic                   [`MEM_BANKS-1:0] cycle_done,
  output mem_ref_pkg::bank_ctl_t [`MEM_BANKS-1:0] ctl,
  output mem_ref_pkg::ref_event_t                 ref_event,
  output logic                                   ref_strobe_n
);

  localparam int unsigned ack_w = $clog2(`REF_ACK_DELAY + 1);
  localparam logic [ack_w-1:0] ack_last = ack_w'(`REF_ACK_DELAY - 1);

  mem_ref_pkg::bank_idx_t last_idx;   // Last bank served.
  mem_ref_pkg::bank_idx_t gnt_idx;
  mem_ref_pkg::bank_idx_t pick_idx;
  logic                   pick_valid;
  logic                   busy;
  logic                   svga_req_sel;
  logic [ack_w-1:0]       acc_cnt;
  logic                   ack_q;
  logic                   done_q;

  // Search starts one past the last bank served.
  always_comb begin
    int cand;
    pick_valid = 1'b0;
    pick_idx   = last_idx;
    for (int i = 1; i <= `MEM_BANKS; i++) begin
      cand = (int'(last_idx) + i) % `MEM_BANKS;
      if (!pick_valid && req[cand].ref_req) begin
        pick_valid = 1'b1;
        pick_idx   = mem_ref_pkg::bank_idx_t'(cand);
      end
    end
  end

  // One grant at a time, held until the bank reports done.
  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      busy     <= 1'b0;
      gnt_idx  <= '0;
      last_idx <= mem_ref_pkg::bank_idx_t'(`MEM_BANKS - 1);
    end else if (!busy) begin
      if (pick_valid) begin
        busy    <= 1'b1;
        gnt_idx <= pick_idx;
      end
    end else if (cycle_done[gnt_idx]) begin
      busy     <= 1'b0;
      last_idx <= gnt_idx;
    end
  end

  assign svga_req_sel = busy & req[gnt_idx].svga_req;

  // Access timer.
  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      acc_cnt <= '0;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (!svga_req_sel || ack_q) begin
        acc_cnt <= '0;
      end else if (acc_cnt == ack_last) begin
        acc_cnt <= '0;
        ack_q   <= 1'b1;               // Access complete.
      end else begin
        acc_cnt <= acc_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= busy & cycle_done[gnt_idx];
    end
  end

  always_comb begin
    for (int i = 0; i < `MEM_BANKS; i++) begin
      ctl[i].ref_gnt  = busy && (gnt_idx == mem_ref_pkg::bank_idx_t'(i));
      ctl[i].svga_ack = ack_q && (gnt_idx == mem_ref_pkg::bank_idx_t'(i));
    end
  end

  // The grant index is only replaced after the done cycle.
  assign ref_event = '{
    strobe: ack_q,
    done:   done_q,
    bank:   gnt_idx
  };

  // Memory strobe follows the granted access.
  assign ref_strobe_n = ~svga_req_sel;

endmodule

`default_nettype wire

//--- sm_ref.sv
`default_nettype none

`include "mem_ref_config.svh"

module sm_ref (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  input  logic                   sync_line_end,
  input  logic                   cr11_long,
  input  mem_ref_pkg::bank_ctl_t ctl,
  output mem_ref_pkg::bank_req_t req,
  output logic                   ref_cycle_done
);

  localparam logic [`REF_CNT_W-1:0] cnt_short = `REF_CNT_SHORT;
  localparam logic [`REF_CNT_W-1:0] cnt_long  = `REF_CNT_LONG;

  mem_ref_pkg::ref_state_e current_state;
  mem_ref_pkg::ref_state_e next_state;
  logic [`REF_CNT_W-1:0]   rfsh_cnt;
  logic                    long_burst;
  logic                    rfsh_done;

  assign rfsh_done = long_burst ? (rfsh_cnt == cnt_long) : (rfsh_cnt == cnt_short);

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      current_state <= mem_ref_pkg::ref_idle;
    end else begin
      current_state <= next_state;
    end
  end

  always_comb begin
    next_state = current_state;
    case (current_state)
      mem_ref_pkg::ref_idle: begin
        if (sync_line_end) begin
          next_state = mem_ref_pkg::ref_request;
        end
      end
      mem_ref_pkg::ref_request: begin
        if (ctl.ref_gnt) begin
          next_state = mem_ref_pkg::ref_access;
        end
      end
      mem_ref_pkg::ref_access: begin
        if (ctl.svga_ack) begin
          next_state = mem_ref_pkg::ref_count;
        end
      end
      mem_ref_pkg::ref_count: begin
        next_state = mem_ref_pkg::ref_check;
      end
      mem_ref_pkg::ref_check: begin
        next_state = rfsh_done ? mem_ref_pkg::ref_done : mem_ref_pkg::ref_access;
      end
      mem_ref_pkg::ref_done: begin
        next_state = mem_ref_pkg::ref_idle;
      end
      default: begin
        next_state = mem_ref_pkg::ref_idle;
      end
    endcase
  end

  // Length is fixed when the burst is accepted.
  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      long_burst <= 1'b0;
    end else if (current_state == mem_ref_pkg::ref_idle && sync_line_end) begin
      long_burst <= cr11_long;
    end
  end

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      rfsh_cnt <= '0;
    end else if (current_state == mem_ref_pkg::ref_done) begin
      rfsh_cnt <= '0;
    end else if (current_state == mem_ref_pkg::ref_count) begin
      rfsh_cnt <= rfsh_cnt + 1'b1;     // One refresh cycle finished.
    end
  end

  // Request drops as soon as the grant shows up.
  assign req.ref_req  = (current_state == mem_ref_pkg::ref_request) & ~ctl.ref_gnt;
  assign req.svga_req = (current_state == mem_ref_pkg::ref_access);

  assign ref_cycle_done = (current_state == mem_ref_pkg::ref_done);

endmodule

`default_nettype wire

//--- src.f
+incdir+.
mem_ref_pkg.sv
crt_ref_trigger.sv
sm_ref.sv
ref_arbiter.sv
mem_ref_top.sv
tb_mem_ref.sv

//--- tb_mem_ref.sv
`default_nettype none

`include "mem_ref_config.svh"

module tb_mem_ref;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic       cr11;      // CR11 bit 6 at the line end.
    logic [7:0] gap;       // Cycles up to the next line end.
    logic [3:0] strobes;   // Strobes per bank for a burst of this line.
  } row_t;

  localparam int n_fixed  = 6;
  localparam int n_random = 6;
  localparam int n_rows   = n_fixed + n_random;

  logic                    mem_clk;
  logic                    hreset_n;
  logic                    line_end;
  logic                    cr11_b6;
  mem_ref_pkg::ref_event_t ref_event;
  logic                    ref_strobe_n;

  row_t   stim [n_rows];
  integer seed;
  int     max_gap;
  int     timeout_cycles;
  logic   table_ready;
  int     error_count;

  // Reference model state.
  logic                   bank_busy [`MEM_BANKS];
  logic                   requested [`MEM_BANKS];
  int                     exp_len [`MEM_BANKS];
  int                     strobe_cnt [`MEM_BANKS];
  int                     fall_cnt [`MEM_BANKS];
  logic                   arb_free;
  mem_ref_pkg::bank_idx_t cur_grant;
  mem_ref_pkg::bank_idx_t last_served;
  logic                   accept_pending;
  int                     accept_len;
  logic                   prev_strobe_n;
  logic                   prev_strobe;
  int                     skipped;

  mem_ref_top DUT (
    .mem_clk      (mem_clk),
    .hreset_n     (hreset_n),
    .line_end     (line_end),
    .cr11_b6      (cr11_b6),
    .ref_event    (ref_event),
    .ref_strobe_n (ref_strobe_n)
  );

  initial begin
    mem_clk = 1'b0;
    forever #10 mem_clk = ~mem_clk;
  end

  task automatic fail_now(input string msg);
    error_count++;
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_event(input mem_ref_pkg::ref_event_t got,
                             input mem_ref_pkg::ref_event_t exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("%s: got strobe=%b done=%b bank=%0d, expected strobe=%b done=%b bank=%0d",
                         what, got.strobe, got.done, got.bank, exp.strobe, exp.done, exp.bank));
    end
  endtask

  task automatic check_count(input mem_ref_pkg::bank_idx_t bank, input int got, input int exp,
                             input string what);
    if (got != exp) begin
      fail_now($sformatf("bank %0d %s: got %0d, expected %0d", bank, what, got, exp));
    end
  endtask

  task automatic check_strobe_n(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("ref_strobe_n %s: got %b, expected %b", what, got, exp));
    end
  endtask

  function automatic logic any_busy();
    logic busy;
    busy = 1'b0;
    for (int b = 0; b < `MEM_BANKS; b++) begin
      busy = busy | bank_busy[b];
    end
    return busy;
  endfunction

  task automatic build_table();
    integer r;
    stim[0] = '{cr11: 1'b0, gap: 8'd100, strobes: 4'(`REF_CNT_SHORT)};
    stim[1] = '{cr11: 1'b1, gap: 8'd150, strobes: 4'(`REF_CNT_LONG)};
    stim[2] = '{cr11: 1'b0, gap: 8'd30,  strobes: 4'(`REF_CNT_SHORT)};  // Next one hits busy banks.
    stim[3] = '{cr11: 1'b1, gap: 8'd40,  strobes: 4'(`REF_CNT_LONG)};
    stim[4] = '{cr11: 1'b1, gap: 8'd150, strobes: 4'(`REF_CNT_LONG)};
    stim[5] = '{cr11: 1'b0, gap: 8'd90,  strobes: 4'(`REF_CNT_SHORT)};
    for (int i = n_fixed; i < n_rows; i++) begin
      r = $random(seed);
      stim[i].gap = 8'(20 + (r & 127));
      r = $random(seed);
      stim[i].cr11    = r[0];
      stim[i].strobes = r[0] ? 4'(`REF_CNT_LONG) : 4'(`REF_CNT_SHORT);
    end
    max_gap = 0;
    for (int i = 0; i < n_rows; i++) begin
      if (stim[i].gap > max_gap) begin
        max_gap = stim[i].gap;
      end
    end
    timeout_cycles = n_rows * max_gap + 200;
  endtask

  // One sample per cycle, taken at the falling edge before new inputs.
  task automatic sample_outputs();
    mem_ref_pkg::ref_event_t ev;
    mem_ref_pkg::ref_event_t exp_ev;
    logic                    strobe_n;
    int                      cand;
    ev       = ref_event;
    strobe_n = ref_strobe_n;
    if (strobe_n === 1'b0 && prev_strobe_n === 1'b1 && !arb_free) begin
      fall_cnt[cur_grant]++;
    end
    if (strobe_n === 1'b1 && prev_strobe_n === 1'b0 && !prev_strobe) begin
      fail_now("ref_strobe_n went high without a strobe at the end of the access");
    end
    if (arb_free) begin
      check_strobe_n(strobe_n, 1'b1, "while no bank is granted");
    end
    if (ev.strobe === 1'b1) begin
      if (arb_free) begin
        fail_now("strobe while no bank is granted");
      end
      exp_ev = '{strobe: 1'b1, done: 1'b0, bank: cur_grant};
      check_event(ev, exp_ev, "strobe event");
      check_strobe_n(strobe_n, 1'b0, "during a strobe");
      strobe_cnt[cur_grant]++;
    end
    if (ev.done === 1'b1) begin
      if (arb_free) begin
        fail_now("done while no bank is granted");
      end
      exp_ev = '{strobe: 1'b0, done: 1'b1, bank: cur_grant};
      check_event(ev, exp_ev, "done event");
      if (!bank_busy[cur_grant]) begin
        fail_now($sformatf("done from bank %0d without an accepted line end", cur_grant));
      end
      check_count(cur_grant, strobe_cnt[cur_grant], exp_len[cur_grant], "strobes in burst");
      check_count(cur_grant, fall_cnt[cur_grant], strobe_cnt[cur_grant],
                  "ref_strobe_n falling edges");
      strobe_cnt[cur_grant] = 0;
      fall_cnt[cur_grant]   = 0;
      bank_busy[cur_grant]  = 1'b0;
      last_served           = cur_grant;
      arb_free              = 1'b1;
    end
    // Round robin from one past the last bank served.
    if (arb_free) begin
      for (int i = 1; i <= `MEM_BANKS; i++) begin
        cand = (int'(last_served) + i) % `MEM_BANKS;
        if (arb_free && requested[cand]) begin
          requested[cand] = 1'b0;
          cur_grant       = mem_ref_pkg::bank_idx_t'(cand);
          arb_free        = 1'b0;
        end
      end
    end
    if (accept_pending) begin
      for (int b = 0; b < `MEM_BANKS; b++) begin
        if (bank_busy[b]) begin
          skipped++;                   // Busy bank ignores the line end.
        end else begin
          bank_busy[b] = 1'b1;
          requested[b] = 1'b1;
          exp_len[b]   = accept_len;
        end
      end
      accept_pending = 1'b0;
    end
    prev_strobe_n = strobe_n;
    prev_strobe   = ev.strobe;
  endtask

  task automatic step();
    @(negedge mem_clk);
    sample_outputs();
  endtask

  task automatic apply_row(input row_t row);
    cr11_b6        = row.cr11;
    line_end       = 1'b1;
    accept_pending = 1'b1;
    accept_len     = row.strobes;
    step();
    line_end = 1'b0;
    for (int c = 1; c < row.gap; c++) begin
      if (c == row.gap / 2) begin
        cr11_b6 = ~row.cr11;           // Mid line CR11 write.
      end
      step();
    end
  endtask

  initial begin
    wait (table_ready === 1'b1);
    repeat (timeout_cycles) @(posedge mem_clk);
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    hreset_n       = 1'b0;
    line_end       = 1'b0;
    cr11_b6        = 1'b0;
    seed           = 32'h5e3e_3de7;
    error_count    = 0;
    table_ready    = 1'b0;
    arb_free       = 1'b1;
    cur_grant      = '0;
    last_served    = mem_ref_pkg::bank_idx_t'(`MEM_BANKS - 1);
    accept_pending = 1'b0;
    accept_len     = 0;
    prev_strobe_n  = 1'b1;
    prev_strobe    = 1'b0;
    skipped        = 0;
    for (int b = 0; b < `MEM_BANKS; b++) begin
      bank_busy[b]  = 1'b0;
      requested[b]  = 1'b0;
      exp_len[b]    = 0;
      strobe_cnt[b] = 0;
      fall_cnt[b]   = 0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge mem_clk);
    @(negedge mem_clk);
    hreset_n = 1'b1;
    repeat (5) step();                 // Quiet before the first line end.
    for (int r = 0; r < n_rows; r++) begin
      apply_row(stim[r]);
    end
    while (!arb_free || any_busy()) begin
      step();
    end
    repeat (10) step();
    if (skipped == 0) begin
      $display("No line end arrived while a bank was still busy");
      error_count++;
    end
    if (error_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "end of run with errors");
    end
  end

endmodule

`default_nettype wire
